// File: source/tcb_mem_pkg.sv
package tcb_mem_pkg;

  //////////////////////////////////////////////////
  // memory geometry
  //////////////////////////////////////////////////

  // total memory size in bytes
  localparam int unsigned TCB_MEM_SIZE = 256;
  // byte lanes on the bus, one bank per lane
  localparam int unsigned TCB_BEN = 4;
  // read request to response, in tcb cycles
  localparam int unsigned TCB_RSP_DLY = 2;
  // rows in each byte bank
  localparam int unsigned TCB_ROWS = TCB_MEM_SIZE / TCB_BEN;

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////

  // byte address
  typedef logic [$clog2(TCB_MEM_SIZE)-1:0] tcb_adr_t;
  // log2 of transfer size, 3 counts as full word
  typedef logic [1:0] tcb_siz_t;
  // row inside one bank
  typedef logic [$clog2(TCB_ROWS)-1:0] tcb_row_t;
  // bus data, byte 0 in low bits
  typedef logic [8*TCB_BEN-1:0] tcb_data_t;
  typedef logic [7:0] tcb_byte_t;
  // one bit per bank
  typedef logic [TCB_BEN-1:0] tcb_lane_t;
  // byte offset inside a word
  typedef logic [$clog2(TCB_BEN)-1:0] tcb_off_t;
  // transfer length in bytes, 1 up to TCB_BEN
  typedef logic [$clog2(TCB_BEN):0] tcb_len_t;

  // size code to byte count
  function automatic tcb_len_t tcb_siz_len(input tcb_siz_t siz);
    tcb_len_t len;
    case (siz)
      2'd0: len = tcb_len_t'(1);
      2'd1: len = tcb_len_t'(2);
      // 2 and 3 both mean a full word
      default: len = tcb_len_t'(TCB_BEN);
    endcase
    return len;
  endfunction

endpackage

// File: source/tcb_mem_req_decode.sv
`timescale 1ns/1ps

module tcb_mem_req_decode (
  // request address and log size
  input  tcb_mem_pkg::tcb_adr_t                               adr,
  input  tcb_mem_pkg::tcb_siz_t                               siz,
  // write data in bus lanes
  input  tcb_mem_pkg::tcb_data_t                              wdt,
  // per bank row, enable and write byte
  output tcb_mem_pkg::tcb_row_t  [tcb_mem_pkg::TCB_BEN-1:0]   bank_row,
  output tcb_mem_pkg::tcb_lane_t                              bank_en,
  output tcb_mem_pkg::tcb_byte_t [tcb_mem_pkg::TCB_BEN-1:0]   bank_wdt
);

  //////////////////////////////////////////////////
  // address split
  //////////////////////////////////////////////////

  // byte offset inside the word
  tcb_mem_pkg::tcb_off_t off;
  // row of the first byte
  tcb_mem_pkg::tcb_row_t row;
  // bytes in this transfer
  tcb_mem_pkg::tcb_len_t len;
  // write data viewed as bytes
  tcb_mem_pkg::tcb_byte_t [tcb_mem_pkg::TCB_BEN-1:0] wdt_byte;

  // low address bits pick the starting bank
  assign off = tcb_mem_pkg::tcb_off_t'(adr);
  // upper address bits pick the row
  assign row = tcb_mem_pkg::tcb_row_t'(adr >> $bits(tcb_mem_pkg::tcb_off_t));
  assign len = tcb_mem_pkg::tcb_siz_len(siz);
  assign wdt_byte = wdt;

  //////////////////////////////////////////////////
  // per bank mapping
  //////////////////////////////////////////////////

  for (genvar k = 0; k < tcb_mem_pkg::TCB_BEN; k++) begin : g_bank

    // request byte that lands in bank k
    tcb_mem_pkg::tcb_off_t b;

    // k minus offset, wraps modulo lane count
    assign b = tcb_mem_pkg::tcb_off_t'(k) - off;

    // bank takes part only for bytes below size
    assign bank_en[k] = ({1'b0, b} < len);

    // banks left of the offset hold the wrapped bytes
    // so they sit one row further, row wraps at the top
    assign bank_row[k] = (tcb_mem_pkg::tcb_off_t'(k) < off) ? row + 1'b1 : row;

    // rotate write data into bank order
    assign bank_wdt[k] = wdt_byte[b];

  end : g_bank

endmodule

// File: source/tcb_mem_banks.sv
`timescale 1ns/1ps

module tcb_mem_banks (
  input  logic                                                tcb,
  input  logic                                                arst_n,
  // port 0 request strobe and write flag
  input  logic                                                vld,
  input  logic                                                wen,
  // lanes touched by the port 0 request
  input  tcb_mem_pkg::tcb_lane_t                              we,
  // write side, one row and byte per bank
  input  tcb_mem_pkg::tcb_row_t  [tcb_mem_pkg::TCB_BEN-1:0]   wr_row,
  input  tcb_mem_pkg::tcb_byte_t [tcb_mem_pkg::TCB_BEN-1:0]   wr_dat,
  // read side for port 0
  input  tcb_mem_pkg::tcb_row_t  [tcb_mem_pkg::TCB_BEN-1:0]   rd0_row,
  output tcb_mem_pkg::tcb_byte_t [tcb_mem_pkg::TCB_BEN-1:0]   rd0_dat,
  // read side for port 1
  input  tcb_mem_pkg::tcb_row_t  [tcb_mem_pkg::TCB_BEN-1:0]   rd1_row,
  output tcb_mem_pkg::tcb_byte_t [tcb_mem_pkg::TCB_BEN-1:0]   rd1_dat
);

  //////////////////////////////////////////////////
  // write enable
  //////////////////////////////////////////////////

  // per bank write strobe
  tcb_mem_pkg::tcb_lane_t wr_en;
  // port 0 is writing this cycle
  logic                   wr_req;

  // writes held off while reset is asserted
  assign wr_req = vld & wen & arst_n;

  // only lanes inside the transfer get written
  assign wr_en = we & {tcb_mem_pkg::TCB_BEN{wr_req}};

  //////////////////////////////////////////////////
  // byte banks
  //////////////////////////////////////////////////

  for (genvar k = 0; k < tcb_mem_pkg::TCB_BEN; k++) begin : g_bank

    // storage for bank k
    tcb_mem_pkg::tcb_byte_t mem [tcb_mem_pkg::TCB_ROWS];

    // single clocked write port
    always_ff @(posedge tcb) begin
      if (wr_en[k]) begin
        mem[wr_row[k]] <= wr_dat[k];
      end
    end

    // two asynchronous read ports
    // a read in the write cycle still sees the old byte
    assign rd0_dat[k] = mem[rd0_row[k]];
    assign rd1_dat[k] = mem[rd1_row[k]];

  end : g_bank

endmodule

// File: source/tcb_mem_rsp_delay.sv
`timescale 1ns/1ps

module tcb_mem_rsp_delay (
  input  logic                                                tcb,
  input  logic                                                arst_n,
  // read request strobe
  input  logic                                                vld,
  // request offset and size, kept for realignment
  input  tcb_mem_pkg::tcb_off_t                               off,
  input  tcb_mem_pkg::tcb_siz_t                               siz,
  // raw bytes in bank order
  input  tcb_mem_pkg::tcb_byte_t [tcb_mem_pkg::TCB_BEN-1:0]   raw,
  output logic                                                rsp_vld,
  output tcb_mem_pkg::tcb_data_t                              rdt
);

  //////////////////////////////////////////////////
  // delay pipeline
  //////////////////////////////////////////////////

  logic                  [tcb_mem_pkg::TCB_RSP_DLY-1:0] dly_vld;
  tcb_mem_pkg::tcb_off_t [tcb_mem_pkg::TCB_RSP_DLY-1:0] dly_off;
  tcb_mem_pkg::tcb_siz_t [tcb_mem_pkg::TCB_RSP_DLY-1:0] dly_siz;
  tcb_mem_pkg::tcb_byte_t [tcb_mem_pkg::TCB_RSP_DLY-1:0][tcb_mem_pkg::TCB_BEN-1:0] dly_raw;
  // realigned response bytes
  tcb_mem_pkg::tcb_byte_t [tcb_mem_pkg::TCB_BEN-1:0] lanes;

  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      dly_vld <= '0;
      dly_off <= '0;
      dly_siz <= '0;
      dly_raw <= '0;
    end else begin
      // stage 0 captures the request
      dly_vld[0] <= vld;
      dly_off[0] <= off;
      dly_siz[0] <= siz;
      dly_raw[0] <= raw;
      // remaining stages shift along
      for (int d = 1; d < tcb_mem_pkg::TCB_RSP_DLY; d++) begin
        dly_vld[d] <= dly_vld[d-1];
        dly_off[d] <= dly_off[d-1];
        dly_siz[d] <= dly_siz[d-1];
        dly_raw[d] <= dly_raw[d-1];
      end
    end
  end

  //////////////////////////////////////////////////
  // realign to bus lanes
  //////////////////////////////////////////////////

  always_comb begin
    tcb_mem_pkg::tcb_off_t bank;
    tcb_mem_pkg::tcb_len_t len;
    len = tcb_mem_pkg::tcb_siz_len(dly_siz[tcb_mem_pkg::TCB_RSP_DLY-1]);
    for (int b = 0; b < tcb_mem_pkg::TCB_BEN; b++) begin
      // lane b comes from bank (off+b) mod lanes
      bank = dly_off[tcb_mem_pkg::TCB_RSP_DLY-1] + tcb_mem_pkg::tcb_off_t'(b);
      // zero fill past transfer size
      if (tcb_mem_pkg::tcb_len_t'(b) < len) begin
        lanes[b] = dly_raw[tcb_mem_pkg::TCB_RSP_DLY-1][bank];
      end else begin
        lanes[b] = '0;
      end
    end
  end

  assign rsp_vld = dly_vld[tcb_mem_pkg::TCB_RSP_DLY-1];
  assign rdt     = lanes;

endmodule

// File: source/tcb_mem_top.sv
`timescale 1ns/1ps

module tcb_mem_top (
  input  logic                   tcb,
  input  logic                   arst_n,
  // port 0, read and write
  input  logic                   p0_vld,
  input  logic                   p0_wen,
  input  tcb_mem_pkg::tcb_adr_t  p0_adr,
  input  tcb_mem_pkg::tcb_siz_t  p0_siz,
  input  tcb_mem_pkg::tcb_data_t p0_wdt,
  output logic                   p0_rsp_vld,
  output tcb_mem_pkg::tcb_data_t p0_rdt,
  // port 1, read only
  input  logic                   p1_vld,
  input  tcb_mem_pkg::tcb_adr_t  p1_adr,
  input  tcb_mem_pkg::tcb_siz_t  p1_siz,
  output logic                   p1_rsp_vld,
  output tcb_mem_pkg::tcb_data_t p1_rdt
);

  //////////////////////////////////////////////////
  // internal wires
  //////////////////////////////////////////////////

  // port 0 decoded request
  tcb_mem_pkg::tcb_row_t  [tcb_mem_pkg::TCB_BEN-1:0] p0_row;
  tcb_mem_pkg::tcb_lane_t                            p0_en;
  tcb_mem_pkg::tcb_byte_t [tcb_mem_pkg::TCB_BEN-1:0] p0_bank_wdt;
  // port 1 decoded rows
  tcb_mem_pkg::tcb_row_t  [tcb_mem_pkg::TCB_BEN-1:0] p1_row;
  // raw bank bytes per port
  tcb_mem_pkg::tcb_byte_t [tcb_mem_pkg::TCB_BEN-1:0] p0_raw;
  tcb_mem_pkg::tcb_byte_t [tcb_mem_pkg::TCB_BEN-1:0] p1_raw;
  // read strobe, a port 0 write gets no response
  logic                                              p0_rd;

  assign p0_rd = p0_vld & ~p0_wen;

  //////////////////////////////////////////////////
  // request decode
  //////////////////////////////////////////////////

  tcb_mem_req_decode u_p0_dec (
    .adr      (p0_adr),
    .siz      (p0_siz),
    .wdt      (p0_wdt),
    .bank_row (p0_row),
    .bank_en  (p0_en),
    .bank_wdt (p0_bank_wdt)
  );

  // read only, no write data and lane mask not needed
  tcb_mem_req_decode u_p1_dec (
    .adr      (p1_adr),
    .siz      (p1_siz),
    .wdt      ('0),
    .bank_row (p1_row),
    .bank_en  (),
    .bank_wdt ()
  );

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  tcb_mem_banks u_banks (
    .tcb     (tcb),
    .arst_n  (arst_n),
    .vld     (p0_vld),
    .wen     (p0_wen),
    .we      (p0_en),
    .wr_row  (p0_row),
    .wr_dat  (p0_bank_wdt),
    .rd0_row (p0_row),
    .rd0_dat (p0_raw),
    .rd1_row (p1_row),
    .rd1_dat (p1_raw)
  );

  //////////////////////////////////////////////////
  // response pipelines
  //////////////////////////////////////////////////

  tcb_mem_rsp_delay u_p0_rsp (
    .tcb     (tcb),
    .arst_n  (arst_n),
    .vld     (p0_rd),
    .off     (tcb_mem_pkg::tcb_off_t'(p0_adr)),
    .siz     (p0_siz),
    .raw     (p0_raw),
    .rsp_vld (p0_rsp_vld),
    .rdt     (p0_rdt)
  );

  tcb_mem_rsp_delay u_p1_rsp (
    .tcb     (tcb),
    .arst_n  (arst_n),
    .vld     (p1_vld),
    .off     (tcb_mem_pkg::tcb_off_t'(p1_adr)),
    .siz     (p1_siz),
    .raw     (p1_raw),
    .rsp_vld (p1_rsp_vld),
    .rdt     (p1_rdt)
  );

endmodule

// File: tb/tcb_mem_tb.sv
`timescale 1ns/1ps

module tcb_mem_tb;

  //////////////////////////////////////////////////
  // dut signals and model state
  //////////////////////////////////////////////////

  logic                   tcb;
  logic                   arst_n;
  logic                   p0_vld;
  logic                   p0_wen;
  tcb_mem_pkg::tcb_adr_t  p0_adr;
  tcb_mem_pkg::tcb_siz_t  p0_siz;
  tcb_mem_pkg::tcb_data_t p0_wdt;
  logic                   p0_rsp_vld;
  tcb_mem_pkg::tcb_data_t p0_rdt;
  logic                   p1_vld;
  tcb_mem_pkg::tcb_adr_t  p1_adr;
  tcb_mem_pkg::tcb_siz_t  p1_siz;
  logic                   p1_rsp_vld;
  tcb_mem_pkg::tcb_data_t p1_rdt;

  // reference bytes, follow every accepted write
  tcb_mem_pkg::tcb_byte_t ref_mem [tcb_mem_pkg::TCB_MEM_SIZE];
  // expected read data per port and the cycle it is due
  int unsigned            p0_due_q [$];
  tcb_mem_pkg::tcb_data_t p0_exp_q [$];
  int unsigned            p1_due_q [$];
  tcb_mem_pkg::tcb_data_t p1_exp_q [$];
  // rising edges seen so far
  int unsigned            cyc = 0;
  int unsigned            errors = 0;
  int unsigned            checks = 0;
  int unsigned            err_mark = 0;
  int unsigned            pass_cnt = 0;
  int unsigned            fail_cnt = 0;
  logic [31:0]            lfsr = 32'h1b31fc48;

  tcb_mem_top uut (.*);

  always #50 tcb = ~tcb;

  always @(posedge tcb) cyc <= cyc + 1;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  // 1, 2 or 4 bytes; code 3 is a full word too
  function automatic int size_bytes(input tcb_mem_pkg::tcb_siz_t siz);
    return (siz == 2'd0) ? 1 : (siz == 2'd1) ? 2 : 4;
  endfunction

  // odd multiplier, so each address gets its own byte
  function automatic tcb_mem_pkg::tcb_byte_t fill(input int a);
    return tcb_mem_pkg::tcb_byte_t'(a * 37 + 90);
  endfunction

  // byte b from address adr+b, upper lanes zero
  function automatic tcb_mem_pkg::tcb_data_t read_ref(input tcb_mem_pkg::tcb_adr_t adr,
                                                      input tcb_mem_pkg::tcb_siz_t siz);
    tcb_mem_pkg::tcb_data_t val;
    val = '0;
    for (int b = 0; b < size_bytes(siz); b++) begin
      val[8*b +: 8] = ref_mem[tcb_mem_pkg::tcb_adr_t'(adr + b)];
    end
    return val;
  endfunction

  // one clock of stimulus on both ports
  task automatic step(input logic vld0, input logic wen0, input tcb_mem_pkg::tcb_adr_t adr0,
                      input tcb_mem_pkg::tcb_siz_t siz0, input tcb_mem_pkg::tcb_data_t wdt0,
                      input logic vld1, input tcb_mem_pkg::tcb_adr_t adr1,
                      input tcb_mem_pkg::tcb_siz_t siz1);
    @(negedge tcb);
    // request edge is cyc+1, response is up mid cycle after edge cyc+2
    // reads take the contents from before this cycle's write
    if (vld0 && !wen0) begin
      p0_due_q.push_back(cyc + tcb_mem_pkg::TCB_RSP_DLY);
      p0_exp_q.push_back(read_ref(adr0, siz0));
    end
    if (vld1) begin
      p1_due_q.push_back(cyc + tcb_mem_pkg::TCB_RSP_DLY);
      p1_exp_q.push_back(read_ref(adr1, siz1));
    end
    if (vld0 && wen0) begin
      for (int b = 0; b < size_bytes(siz0); b++) begin
        ref_mem[tcb_mem_pkg::tcb_adr_t'(adr0 + b)] = wdt0[8*b +: 8];
      end
    end
    p0_vld = vld0;
    p0_wen = wen0;
    p0_adr = adr0;
    p0_siz = siz0;
    p0_wdt = wdt0;
    p1_vld = vld1;
    p1_adr = adr1;
    p1_siz = siz1;
  endtask

  task automatic write0(input tcb_mem_pkg::tcb_adr_t adr, input tcb_mem_pkg::tcb_siz_t siz,
                        input tcb_mem_pkg::tcb_data_t wdt);
    step(1'b1, 1'b1, adr, siz, wdt, 1'b0, '0, '0);
  endtask

  task automatic read_both(input tcb_mem_pkg::tcb_adr_t adr0, input tcb_mem_pkg::tcb_siz_t siz0,
                           input tcb_mem_pkg::tcb_adr_t adr1, input tcb_mem_pkg::tcb_siz_t siz1);
    step(1'b1, 1'b0, adr0, siz0, '0, 1'b1, adr1, siz1);
  endtask

  task automatic idle(input int n);
    for (int i = 0; i < n; i++) begin
      step(1'b0, 1'b0, '0, '0, '0, 1'b0, '0, '0);
    end
  endtask

  // idle until every queued response has come out
  task automatic drain();
    int n;
    n = 0;
    while ((p0_due_q.size() != 0 || p1_due_q.size() != 0) && n < 16) begin
      idle(1);
      n++;
    end
    if (p0_due_q.size() != 0 || p1_due_q.size() != 0) begin
      $display("timeout: read responses still pending after %0d idle cycles", n);
      errors++;
      // stale entries would misalign the next test
      p0_due_q.delete();
      p0_exp_q.delete();
      p1_due_q.delete();
      p1_exp_q.delete();
    end
  endtask

  task automatic end_test(input string name);
    if (errors == err_mark) begin
      pass_cnt++;
      $display("test %-36s ok", name);
    end else begin
      fail_cnt++;
      $display("test %-36s failed with %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  //////////////////////////////////////////////////
  // response checks, mid cycle where outputs are settled
  //////////////////////////////////////////////////

  always @(negedge tcb) begin : check_rsp
    logic exp0;
    logic exp1;
    if (arst_n) begin
      exp0 = (p0_due_q.size() != 0) && (p0_due_q[0] == cyc);
      exp1 = (p1_due_q.size() != 0) && (p1_due_q[0] == cyc);
      checks += 2;
      assert (p0_rsp_vld === exp0) else begin
        $display("ERR %0t p0_rsp_vld exp %0b got %0b", $time, exp0, p0_rsp_vld);
        errors++;
      end
      assert (p1_rsp_vld === exp1) else begin
        $display("ERR %0t p1_rsp_vld exp %0b got %0b", $time, exp1, p1_rsp_vld);
        errors++;
      end
      if (exp0) begin
        checks++;
        assert (p0_rdt === p0_exp_q[0]) else begin
          $display("ERR %0t p0_rdt exp %h got %h", $time, p0_exp_q[0], p0_rdt);
          errors++;
        end
        void'(p0_due_q.pop_front());
        void'(p0_exp_q.pop_front());
      end
      if (exp1) begin
        checks++;
        assert (p1_rdt === p1_exp_q[0]) else begin
          $display("ERR %0t p1_rdt exp %h got %h", $time, p1_exp_q[0], p1_rdt);
          errors++;
        end
        void'(p1_due_q.pop_front());
        void'(p1_exp_q.pop_front());
      end
    end
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    logic                   v0;
    logic                   w0;
    logic                   v1;
    tcb_mem_pkg::tcb_adr_t  a0;
    tcb_mem_pkg::tcb_adr_t  a1;
    tcb_mem_pkg::tcb_siz_t  s0;
    tcb_mem_pkg::tcb_siz_t  s1;
    tcb_mem_pkg::tcb_data_t d0;
    tcb = 1'b0;
    arst_n = 1'b0;
    p0_vld = 1'b0;
    p0_wen = 1'b0;
    p0_adr = '0;
    p0_siz = '0;
    p0_wdt = '0;
    p1_vld = 1'b0;
    p1_adr = '0;
    p1_siz = '0;
    repeat (10) @(negedge tcb);
    arst_n = 1'b1;

    // quiet ports, then a full fill by word writes
    idle(4);
    for (int a = 0; a < tcb_mem_pkg::TCB_MEM_SIZE; a += 4) begin
      write0(tcb_mem_pkg::tcb_adr_t'(a), 2'd2, {fill(a+3), fill(a+2), fill(a+1), fill(a)});
    end
    idle(4);
    end_test("idle and writes give no response");

    for (int i = 0; i < 8; i++) begin
      write0(tcb_mem_pkg::tcb_adr_t'(8'h10 + 4*i), 2'd2, rand_bits(32));
    end
    // both ports over the same words, in opposite order
    for (int i = 0; i < 8; i++) begin
      read_both(tcb_mem_pkg::tcb_adr_t'(8'h10 + 4*i), 2'd2,
                tcb_mem_pkg::tcb_adr_t'(8'h2c - 4*i), 2'd2);
    end
    drain();
    end_test("aligned words on both ports");

    write0(8'h81, 2'd0, rand_bits(32));
    write0(8'h86, 2'd0, rand_bits(32));
    write0(8'h8b, 2'd0, rand_bits(32));
    write0(8'h91, 2'd1, rand_bits(32));
    write0(8'h96, 2'd1, rand_bits(32));
    // halfword at offset 3 spills into the next row
    write0(8'h9b, 2'd1, rand_bits(32));
    write0(8'ha3, 2'd2, rand_bits(32));
    // wraps past the top of memory
    write0(8'hfe, 2'd3, rand_bits(32));
    for (int a = 8'h80; a < 8'ha8; a++) begin
      read_both(tcb_mem_pkg::tcb_adr_t'(a), tcb_mem_pkg::tcb_siz_t'(a),
                tcb_mem_pkg::tcb_adr_t'(a), tcb_mem_pkg::tcb_siz_t'(a + 1));
    end
    read_both(8'hfe, 2'd2, 8'hff, 2'd1);
    drain();
    end_test("misaligned sizes and zero fill");

    write0(8'h40, 2'd2, rand_bits(32));
    // port 1 reads the word being overwritten
    step(1'b1, 1'b1, 8'h40, 2'd2, rand_bits(32), 1'b1, 8'h40, 2'd2);
    read_both(8'h40, 2'd2, 8'h41, 2'd1);
    drain();
    end_test("read during write sees old data");

    for (int i = 0; i < 200; i++) begin
      v0 = rand_bits(2) != 0;
      w0 = rand_bits(1) != 0;
      a0 = tcb_mem_pkg::tcb_adr_t'(rand_bits(8));
      s0 = tcb_mem_pkg::tcb_siz_t'(rand_bits(2));
      d0 = rand_bits(32);
      v1 = rand_bits(2) != 0;
      // half the time port 1 hits the same address
      a1 = (rand_bits(1) != 0) ? a0 : tcb_mem_pkg::tcb_adr_t'(rand_bits(8));
      s1 = tcb_mem_pkg::tcb_siz_t'(rand_bits(2));
      step(v0, w0, a0, s0, d0, v1, a1, s1);
    end
    drain();
    end_test("random mixed traffic");

    $display("summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
             pass_cnt, fail_cnt, checks, errors);
    if (fail_cnt == 0 && errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
source/tcb_mem_pkg.sv
source/tcb_mem_req_decode.sv
source/tcb_mem_banks.sv
source/tcb_mem_rsp_delay.sv
source/tcb_mem_top.sv
tb/tcb_mem_tb.sv

// File: run.sh
#!/bin/sh
# build and run the tcb memory testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module tcb_mem_tb -f build.f -o tcb_mem_sim

./obj_dir/tcb_mem_sim > sim.log 2>&1
cat sim.log

# the testbench ends normally in both cases, so the log decides
if grep -q "ALL TESTS PASSED" sim.log; then
  exit 0
fi
exit 1
